//--- compile.f
+incdir+tb
hdl/game_pkg.sv
hdl/io_pkg.sv
hdl/countdown.sv
hdl/play_sequencer.sv
hdl/score_keeper.sv
hdl/note_indicator.sv
hdl/save_sender.sv
hdl/play_top.sv
tb/tb_play_top.sv

//--- Bender.yml
package:
  name: play_engine

sources:
  - hdl/game_pkg.sv
  - hdl/io_pkg.sv
  - hdl/countdown.sv
  - hdl/play_sequencer.sv
  - hdl/score_keeper.sv
  - hdl/note_indicator.sv
  - hdl/save_sender.sv
  - hdl/play_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_play_top.sv

//--- tb/tb_play_checks.svh
`ifndef TB_PLAY_CHECKS_SVH
`define TB_PLAY_CHECKS_SVH

// A zero note count plays the whole chart
function automatic int played_notes(chart_t c);
    if (c.info.note_cnt == 0 || c.info.note_cnt > CHART_LEN) begin
        return CHART_LEN;
    end
    return int'(c.info.note_cnt);
endfunction

// Octave lamp on bit 0, C on bit 7 down to B on bit 1
function automatic led_t note_to_led(note_t n);
    led_t l;
    l = '0;
    l[0] = (n.oct_up != n.oct_down);
    for (int k = 0; k < 7; k++) begin
        if (n.keys == 7'(1 << k)) begin
            l[7 - k] = 1'b1;
        end
    end
    return l;
endfunction

function automatic seg_text_t note_to_seg(note_t n);
    string     letters;
    byte       oct;
    seg_text_t s;
    letters = "cdefgab";
    s = "        ";
    if (n.oct_up && n.oct_down) begin
        return s;
    end
    oct = n.oct_up ? "u" : (n.oct_down ? "d" : " ");
    // Rests and chords stay blank
    for (int k = 0; k < 7; k++) begin
        if (n.keys == 7'(1 << k)) begin
            s = {letters[k], " ", oct, " ", 8'(k + 49), "   "};
        end
    end
    return s;
endfunction

// Per sounding note hi gains 4 times 5 and the score 4 times 4 or 5
function automatic void expected_scores(input chart_t c, input logic auto_mode,
                                        input logic free_mode, output score_t s,
                                        output score_t h);
    s = '0;
    h = '0;
    for (int i = 0; i < played_notes(c); i++) begin
        if (!free_mode && c.notes[i].keys != '0) begin
            h = h + score_t'(4 * 5);
            s = s + (auto_mode ? score_t'(4 * 4) : score_t'(4 * 5));
        end
    end
endfunction

// Held keys land in the played slots and later slots stay rests
function automatic chart_save_t expected_chart_save(chart_t c, logic [7:0] id);
    chart_save_t s;
    s.chart_id = id;
    s.chart.info = c.info;
    s.chart.notes = '0;
    for (int i = 0; i < played_notes(c); i++) begin
        s.chart.notes[i] = c.notes[i];
    end
    return s;
endfunction

task automatic check_note(note_t got, note_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_led(led_t got, led_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic check_seg(seg_text_t got, seg_text_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is \"%s\", expected \"%s\"",
                            $time, what, got, exp));
    end
endtask

task automatic check_score(score_t got, score_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

task automatic check_chart_save(chart_save_t got, chart_save_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_record_save(record_save_t got, record_save_t exp, string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

`endif

//--- tb/tb_play_top.sv
module tb_play_top;
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;
    import io_pkg::*;

    localparam int STEP_TIMEOUT = 2 * SCORE_TICK_CYCLES * SCORE_TICKS_PER_NOTE;
    localparam int START_TIMEOUT = 4 * COUNT_STEP_CYCLES + 20;
    localparam logic [7:0] USER_ID = 8'h2a;
    localparam logic [7:0] CHART_ID = 8'h17;

    logic         prog_clk;
    logic         rst;
    user_input_t  user_in;
    chart_t       read_chart;
    logic         auto_play;
    logic         free_play;
    logic [1:0]   count_value;
    logic         playing;
    note_t        play_notes;
    led_t         led;
    seg_text_t    seg;
    score_t       score;
    score_t       hi_score;
    logic         exit_to_menu;
    logic         chart_save_valid;
    chart_save_t  chart_save;
    logic         chart_credit;
    logic         record_save_valid;
    record_save_t record_save;
    logic         record_credit;

    // Checker state
    int           step_cnt;
    logic         play_check_due;
    note_t        due_note;
    int           chart_valid_cnt;
    int           record_valid_cnt;
    chart_save_t  exp_chart_save;
    record_save_t exp_record_save;

    play_top i_dut (.*);

    `include "tb_play_checks.svh"

    initial begin
        prog_clk = 1'b0;
        forever begin
            #20 prog_clk = ~prog_clk;
        end
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic chart_t random_chart();
        chart_t c;
        int     key;
        int     oct;
        c = '0;
        c.info.note_cnt = 8'($urandom_range(0, CHART_LEN));
        c.info.name = "tb chart random ";
        for (int i = 0; i < CHART_LEN; i++) begin
            key = $urandom_range(0, 7);
            oct = $urandom_range(0, 2);
            // Key 7 leaves a rest
            if (key < 7) begin
                c.notes[i].keys = 7'(1 << key);
                c.notes[i].oct_up = (oct == 1);
                c.notes[i].oct_down = (oct == 2);
            end
        end
        return c;
    endfunction

    task automatic hold_note(note_t n);
        user_in.note_keys = n.keys;
        user_in.oct_up = n.oct_up;
        user_in.oct_down = n.oct_down;
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        step_cnt = 0;
        play_check_due = 1'b0;
        chart_valid_cnt = 0;
        record_valid_cnt = 0;
        repeat (5) @(posedge prog_clk);
        if (playing || exit_to_menu || chart_save_valid || record_save_valid
                || count_value != 2'd3) begin
            abort_run($sformatf("[FAIL] %0t ns: control outputs not idle in reset", $time));
        end
        check_score(score, '0, "score in reset");
        check_score(hi_score, '0, "hi_score in reset");
        check_led(led, '0, "led in reset");
        check_seg(seg, "        ", "seg in reset");
        check_note(play_notes, '0, "play_notes in reset");
        #2;
        rst = 1'b0;
    endtask

    // Count values must fall 3, 2, 1, 0 before play starts
    task automatic run_countdown();
        int         cycles;
        logic [1:0] exp_value;
        cycles = 0;
        exp_value = 2'd3;
        while (!playing) begin
            @(negedge prog_clk);
            cycles++;
            if (count_value != exp_value) begin
                if (exp_value != 2'd0 && count_value == exp_value - 2'd1) begin
                    exp_value = exp_value - 2'd1;
                end else begin
                    abort_run($sformatf("[FAIL] %0t ns: count_value %0d out of order",
                                        $time, count_value));
                end
            end
            if (cycles > START_TIMEOUT) begin
                abort_run("Timeout: playing never rose after the countdown");
            end
        end
        if (exp_value != 2'd0 || cycles <= 4 * COUNT_STEP_CYCLES) begin
            abort_run($sformatf("[FAIL] %0t ns: play started after %0d cycles at count %0d",
                                $time, cycles, exp_value));
        end
    endtask

    task automatic wait_step();
        int cycles;
        cycles = 0;
        do begin
            @(negedge prog_clk);
            cycles++;
            if (cycles > STEP_TIMEOUT) begin
                abort_run("Timeout: no note step while the chart was playing");
            end
        end while (!i_dut.step);
    endtask

    task automatic play_run(logic auto_mode, logic free_mode);
        int     played;
        score_t exp_s;
        score_t exp_h;
        @(posedge prog_clk);
        #2;
        auto_play = auto_mode;
        free_play = free_mode;
        played = played_notes(read_chart);
        if (auto_mode) begin
            hold_note('0);
        end else begin
            hold_note(read_chart.notes[0]);
        end
        reset_dut();
        run_countdown();
        // The player switches to the next note right after each step
        for (int k = 0; k < played; k++) begin
            wait_step();
            @(posedge prog_clk);
            #2;
            if (!auto_mode && k + 1 < played) begin
                hold_note(read_chart.notes[k + 1]);
            end
        end
        @(negedge prog_clk);
        if (playing) begin
            abort_run($sformatf("[FAIL] %0t ns: playing still high after the chart", $time));
        end
        expected_scores(read_chart, auto_mode, free_mode, exp_s, exp_h);
        check_score(score, exp_s, "final score");
        check_score(hi_score, exp_h, "final hi_score");
    endtask

    task automatic save_under_backpressure();
        score_t exp_s;
        score_t exp_h;
        int     cycles;
        expected_scores(read_chart, 1'b0, 1'b0, exp_s, exp_h);
        exp_chart_save = expected_chart_save(read_chart, CHART_ID);
        exp_record_save = '{chart_id: CHART_ID, user_id: USER_ID,
                            name: read_chart.info.name, score: exp_s};
        @(posedge prog_clk);
        #2;
        hold_note('0);
        // Three right-arrow edges while no credit comes back
        repeat (3) begin
            user_in.arrow_keys = ARROW_RIGHT;
            @(posedge prog_clk);
            #2;
            user_in.arrow_keys = 2'b00;
            @(posedge prog_clk);
            #2;
        end
        repeat (8) @(posedge prog_clk);
        if (chart_valid_cnt != SAVE_CREDITS || record_valid_cnt != SAVE_CREDITS) begin
            abort_run($sformatf("[FAIL] %0t ns: %0d/%0d saves sent without credits",
                                $time, chart_valid_cnt, record_valid_cnt));
        end
        #2;
        chart_credit = 1'b1;
        record_credit = 1'b1;
        @(posedge prog_clk);
        #2;
        chart_credit = 1'b0;
        record_credit = 1'b0;
        cycles = 0;
        while (chart_valid_cnt < SAVE_CREDITS + 1 || record_valid_cnt < SAVE_CREDITS + 1) begin
            @(posedge prog_clk);
            cycles++;
            if (cycles > 8) begin
                abort_run("Timeout: the merged save was not sent after a credit returned");
            end
        end
        repeat (8) @(posedge prog_clk);
        if (chart_valid_cnt != SAVE_CREDITS + 1 || record_valid_cnt != SAVE_CREDITS + 1) begin
            abort_run($sformatf("[FAIL] %0t ns: %0d/%0d saves after one credit",
                                $time, chart_valid_cnt, record_valid_cnt));
        end
    endtask

    task automatic leave_to_menu();
        int cycles;
        cycles = 0;
        #2;
        user_in.arrow_keys = ARROW_LEFT;
        while (!exit_to_menu) begin
            @(negedge prog_clk);
            cycles++;
            if (cycles > 4) begin
                abort_run("Timeout: exit_to_menu never rose after the left arrow");
            end
        end
        @(posedge prog_clk);
        #2;
        user_in.arrow_keys = 2'b00;
    endtask

    // Step and save checker
    initial begin
        forever begin
            @(negedge prog_clk);
            if (play_check_due) begin
                check_note(play_notes, due_note, "play_notes");
                play_check_due = 1'b0;
            end
            if (i_dut.step) begin
                due_note = read_chart.notes[step_cnt];
                check_led(led, note_to_led(due_note), "led");
                check_seg(seg, note_to_seg(due_note), "seg");
                play_check_due = 1'b1;
                step_cnt++;
            end
            if (chart_save_valid) begin
                check_chart_save(chart_save, exp_chart_save, "chart save payload");
                chart_valid_cnt++;
            end
            if (record_save_valid) begin
                check_record_save(record_save, exp_record_save, "record save payload");
                record_valid_cnt++;
            end
        end
    end

    initial begin
        int seed_value;
        seed_value = $urandom(33);
        rst = 1'b1;
        user_in = '{user_id: USER_ID, chart_id: CHART_ID, default: '0};
        auto_play = 1'b0;
        free_play = 1'b0;
        chart_credit = 1'b0;
        record_credit = 1'b0;
        step_cnt = 0;
        play_check_due = 1'b0;
        due_note = '0;
        chart_valid_cnt = 0;
        record_valid_cnt = 0;
        exp_chart_save = '0;
        exp_record_save = '0;
        read_chart = random_chart();

        play_run(1'b1, 1'b0);
        play_run(1'b0, 1'b0);
        save_under_backpressure();
        leave_to_menu();
        // Free play scores nothing
        play_run(1'b0, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- hdl/play_top.sv
module play_top (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  io_pkg::user_input_t  user_in,
    input  game_pkg::chart_t     read_chart,
    input  logic                 auto_play,
    input  logic                 free_play,
    output logic [1:0]           count_value,
    output logic                 playing,
    output game_pkg::note_t      play_notes,
    output io_pkg::led_t         led,
    output io_pkg::seg_text_t    seg,
    output game_pkg::score_t     score,
    output game_pkg::score_t     hi_score,
    output logic                 exit_to_menu,
    output logic                 chart_save_valid,
    output io_pkg::chart_save_t  chart_save,
    input  logic                 chart_credit,
    output logic                 record_save_valid,
    output io_pkg::record_save_t record_save,
    input  logic                 record_credit
);
    import game_pkg::*;
    import io_pkg::*;

    logic                  play_started;
    logic [NOTE_IDX_W-1:0] note_index;
    logic                  step;
    logic                  score_tick;
    chart_t                recorded_chart;
    play_state_t           state;
    logic                  save_request;
    note_t                 chart_note;
    chart_save_t           chart_payload;
    record_save_t          record_payload;

    assign chart_note = read_chart.notes[note_index];
    assign exit_to_menu = (state == MENU);
    assign chart_payload = '{chart_id: user_in.chart_id, chart: recorded_chart};
    assign record_payload = '{
        chart_id: user_in.chart_id,
        user_id:  user_in.user_id,
        name:     read_chart.info.name,
        score:    score
    };

    countdown i_countdown (
        .prog_clk(prog_clk), .rst(rst),
        .count_value(count_value), .play_started(play_started)
    );

    play_sequencer i_sequencer (
        .prog_clk(prog_clk), .rst(rst), .play_started(play_started),
        .user_in(user_in), .read_chart(read_chart), .auto_play(auto_play),
        .playing(playing), .note_index(note_index), .step(step), .score_tick(score_tick),
        .play_notes(play_notes), .recorded_chart(recorded_chart),
        .state(state), .save_request(save_request)
    );

    score_keeper i_score (
        .prog_clk(prog_clk), .rst(rst), .playing(playing), .score_tick(score_tick),
        .auto_play(auto_play), .free_play(free_play), .user_in(user_in),
        .chart_note(chart_note), .score(score), .hi_score(hi_score)
    );

    note_indicator i_indicator (
        .prog_clk(prog_clk), .rst(rst), .playing(playing),
        .chart_note(chart_note), .led(led), .seg(seg)
    );

    save_sender #(.payload_t(chart_save_t)) i_chart_sender (
        .prog_clk(prog_clk), .rst(rst), .request(save_request),
        .payload_in(chart_payload), .valid(chart_save_valid),
        .payload(chart_save), .credit_return(chart_credit)
    );

    save_sender #(.payload_t(record_save_t)) i_record_sender (
        .prog_clk(prog_clk), .rst(rst), .request(save_request),
        .payload_in(record_payload), .valid(record_save_valid),
        .payload(record_save), .credit_return(record_credit)
    );

endmodule

//--- hdl/save_sender.sv
module save_sender #(
    parameter type payload_t = logic
) (
    input  logic     prog_clk,
    input  logic     rst,
    input  logic     request,
    input  payload_t payload_in,
    output logic     valid,
    output payload_t payload,
    input  logic     credit_return
);
    import io_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                pending;
    logic                wanted;
    logic                avail;
    logic                issue;

    assign wanted = request || pending;
    // A credit returning this cycle can be spent at once
    assign avail = (credits != '0) || credit_return;
    assign issue = wanted && avail;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            credits <= CREDIT_W'(SAVE_CREDITS);
            pending <= 1'b0;
            valid <= 1'b0;
        end else begin
            credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(issue);
            // Requests blocked on credits merge into one
            pending <= wanted && !issue;
            valid <= issue;
        end
    end

    // Latest request wins, so a merged save carries the newest data
    always_ff @(posedge prog_clk) begin
        if (request) begin
            payload <= payload_in;
        end
    end

    a_credit_max: assert property (
        @(posedge prog_clk) disable iff (rst)
        credits <= SAVE_CREDITS
    ) else $error("credit count above limit");

    a_valid_credit: assert property (
        @(posedge prog_clk) disable iff (rst)
        valid |-> $past(credits != '0 || credit_return)
    ) else $error("valid sent without a credit");

endmodule

//--- hdl/note_indicator.sv
module note_indicator (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              playing,
    input  game_pkg::note_t   chart_note,
    output io_pkg::led_t      led,
    output io_pkg::seg_text_t seg
);
    import game_pkg::*;
    import io_pkg::*;

    // Octave lamp on led[0], keys reversed onto led[7:1]
    function automatic led_t note_led(note_t n);
        led_t lamps;
        lamps = '0;
        lamps[0] = n.oct_up ^ n.oct_down;
        if ($onehot(n.keys)) begin
            for (int i = 0; i < 7; i++) begin
                lamps[7 - i] = n.keys[i];
            end
        end
        return lamps;
    endfunction

    // Letter, octave mark and key number, e.g. "e u 3   "
    function automatic seg_text_t note_text(note_t n);
        logic [2:0] pos;
        logic [7:0] octave;
        logic [7:0] digit;
        pos = '0;
        for (int i = 0; i < 7; i++) begin
            if (n.keys[i]) begin
                pos = 3'(i);
            end
        end
        if (n.oct_up) begin
            octave = "u";
        end else if (n.oct_down) begin
            octave = "d";
        end else begin
            octave = " ";
        end
        digit = 8'h31 + 8'(pos);
        if (!$onehot(n.keys) || (n.oct_up && n.oct_down)) begin
            return SEG_BLANK;
        end
        return {NOTE_LETTERS[pos], " ", octave, " ", digit, "   "};
    endfunction

    // Holds the last note once play stops
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= SEG_BLANK;
        end else if (playing) begin
            led <= note_led(chart_note);
            seg <= note_text(chart_note);
        end
    end

endmodule

//--- hdl/score_keeper.sv
module score_keeper (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                playing,
    input  logic                score_tick,
    input  logic                auto_play,
    input  logic                free_play,
    input  io_pkg::user_input_t user_in,
    input  game_pkg::note_t     chart_note,
    output game_pkg::score_t    score,
    output game_pkg::score_t    hi_score
);
    import game_pkg::*;
    import io_pkg::*;

    note_t cur_in;
    // Two most recent inputs seen with a key down
    note_t hist_0;
    note_t hist_1;
    logic  judge;

    assign cur_in = '{
        oct_down: user_in.oct_down,
        oct_up:   user_in.oct_up,
        keys:     user_in.note_keys
    };

    // Rests and free play are never scored
    assign judge = playing && score_tick && !free_play && (chart_note.keys != '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            hi_score <= '0;
            hist_0 <= '0;
            hist_1 <= '0;
        end else if (judge) begin
            hi_score <= hi_score + HI_POINTS;
            if (auto_play) begin
                score <= score + AUTO_POINTS;
            end else if (user_in.note_keys != '0) begin
                hist_0 <= cur_in;
                hist_1 <= hist_0;
                // Earlier matches earn less
                if (chart_note == cur_in) begin
                    score <= score + HIT_POINTS;
                end else if (chart_note == hist_0) begin
                    score <= score + LATE_POINTS;
                end else if (chart_note == hist_1) begin
                    score <= score + LATER_POINTS;
                end
            end
        end
    end

    a_score_bounded: assert property (
        @(posedge prog_clk) disable iff (rst)
        score <= hi_score
    ) else $error("score above hi_score");

endmodule

//--- hdl/play_sequencer.sv
module play_sequencer (
    input  logic                             prog_clk,
    input  logic                             rst,
    input  logic                             play_started,
    input  io_pkg::user_input_t              user_in,
    input  game_pkg::chart_t                 read_chart,
    input  logic                             auto_play,
    output logic                             playing,
    output logic [game_pkg::NOTE_IDX_W-1:0] note_index,
    output logic                             step,
    output logic                             score_tick,
    output game_pkg::note_t                  play_notes,
    output game_pkg::chart_t                 recorded_chart,
    output game_pkg::play_state_t            state,
    output logic                             save_request
);
    import game_pkg::*;
    import io_pkg::*;

    logic [TICK_CNT_W-1:0]        tick_cnt;
    logic [SUB_CNT_W-1:0]         sub_cnt;
    logic                         done;
    logic [NOTE_IDX_W-1:0]        last_index;
    note_t                        user_note;
    note_t [CHART_LEN-1:0]        rec_notes;
    logic                         right_now;
    logic                         right_q;

    assign user_note = '{
        oct_down: user_in.oct_down,
        oct_up:   user_in.oct_up,
        keys:     user_in.note_keys
    };

    assign playing = play_started && !done;

    // A zero note count plays every slot
    always_comb begin
        if (read_chart.info.note_cnt == '0 || read_chart.info.note_cnt > CHART_LEN) begin
            last_index = NOTE_IDX_W'(CHART_LEN - 1);
        end else begin
            last_index = NOTE_IDX_W'(read_chart.info.note_cnt - 1);
        end
    end

    // Score strobe divider with every fourth strobe a note step
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            sub_cnt <= '0;
        end else if (playing) begin
            if (score_tick) begin
                tick_cnt <= '0;
                if (step) begin
                    sub_cnt <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign score_tick = playing && (tick_cnt == TICK_CNT_W'(SCORE_TICK_CYCLES - 1));
    assign step = score_tick && (sub_cnt == SUB_CNT_W'(SCORE_TICKS_PER_NOTE - 1));

    // Note stepping and recording; unplayed slots save as rests
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_index <= '0;
            done <= 1'b0;
            play_notes <= '0;
            rec_notes <= '0;
        end else if (step) begin
            play_notes <= auto_play ? read_chart.notes[note_index] : user_note;
            rec_notes[note_index] <= user_note;
            if (note_index == last_index) begin
                done <= 1'b1;
            end else begin
                note_index <= note_index + 1'b1;
            end
        end
    end

    assign recorded_chart = '{info: read_chart.info, notes: rec_notes};

    // Arrow keys
    assign right_now = (user_in.arrow_keys == ARROW_RIGHT);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            right_q <= 1'b0;
            state <= PLAY;
        end else begin
            right_q <= right_now;
            if (play_started && user_in.arrow_keys == ARROW_LEFT) begin
                state <= MENU;
            end
        end
    end

    assign save_request = play_started && right_now && !right_q;

    // The stop at the last note keeps the index inside the chart
    a_index_range: assert property (
        @(posedge prog_clk) disable iff (rst)
        note_index < CHART_LEN
    ) else $error("note_index out of chart");

endmodule

//--- hdl/countdown.sv
module countdown (
    input  logic       prog_clk,
    input  logic       rst,
    output logic [1:0] count_value,
    output logic       play_started
);
    import game_pkg::*;

    logic [COUNT_CNT_W-1:0] cycle_cnt;
    logic                   phase_end;

    assign phase_end = (cycle_cnt == COUNT_CNT_W'(COUNT_STEP_CYCLES - 1));

    // 3, 2, 1, 0, then play starts and the counter freezes
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
            count_value <= 2'd3;
            play_started <= 1'b0;
        end else if (!play_started) begin
            if (phase_end) begin
                cycle_cnt <= '0;
                if (count_value == 2'd0) begin
                    play_started <= 1'b1;
                end else begin
                    count_value <= count_value - 2'd1;
                end
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/io_pkg.sv
package io_pkg;

    typedef struct packed {
        logic [7:0] user_id;
        logic [7:0] chart_id;
        logic [1:0] arrow_keys;
        logic [6:0] note_keys;
        logic       oct_up;
        logic       oct_down;
    } user_input_t;

    // Arrow codes with 2'b00 for no arrow held
    localparam logic [1:0] ARROW_LEFT = 2'b10;
    localparam logic [1:0] ARROW_RIGHT = 2'b01;

    typedef logic [7:0] led_t;
    typedef logic [7:0][7:0] seg_text_t;

    localparam seg_text_t SEG_BLANK = "        ";
    // Index 0 holds the letter for C
    localparam logic [6:0][7:0] NOTE_LETTERS = "bagfedc";

    // Save channels
    localparam int SAVE_CREDITS = 2;
    localparam int CREDIT_W = $clog2(SAVE_CREDITS + 1);

    typedef struct packed {
        logic [7:0]       chart_id;
        game_pkg::chart_t chart;
    } chart_save_t;

    typedef struct packed {
        logic [7:0]       chart_id;
        logic [7:0]       user_id;
        game_pkg::name_t  name;
        game_pkg::score_t score;
    } record_save_t;

endpackage

//--- hdl/game_pkg.sv
package game_pkg;

    // Chart geometry
    localparam int CHART_LEN = 32;
    localparam int NAME_LEN = 16;
    localparam int NOTE_IDX_W = $clog2(CHART_LEN + 1);

    // Play timing in prog_clk cycles
    localparam int COUNT_STEP_CYCLES = 60;
    localparam int COUNT_CNT_W = $clog2(COUNT_STEP_CYCLES);
    localparam int SCORE_TICK_CYCLES = 8;
    localparam int TICK_CNT_W = $clog2(SCORE_TICK_CYCLES);
    localparam int SCORE_TICKS_PER_NOTE = 4;
    localparam int SUB_CNT_W = $clog2(SCORE_TICKS_PER_NOTE);

    localparam int SCORE_W = 14;
    typedef logic [SCORE_W-1:0] score_t;

    // Points per score strobe
    localparam score_t HI_POINTS = score_t'(5);
    localparam score_t AUTO_POINTS = score_t'(4);
    localparam score_t HIT_POINTS = score_t'(5);
    localparam score_t LATE_POINTS = score_t'(3);
    localparam score_t LATER_POINTS = score_t'(2);

    // One-hot keys with C in bit 0; all zero is a rest
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;
    } note_t;

    typedef logic [NAME_LEN-1:0][7:0] name_t;

    typedef struct packed {
        logic [7:0] note_cnt;
        name_t      name;
    } chart_info_t;

    typedef struct packed {
        chart_info_t                info;
        note_t [CHART_LEN-1:0]      notes;
    } chart_t;

    typedef enum logic {
        PLAY,
        MENU
    } play_state_t;

endpackage
